// File: Bender.yml
package:
  name: mil_buffer_bridge

sources:
  - files:
      - hdl/milStdPkg.sv
      - hdl/milMemEncoder.sv
      - hdl/memMilEncoder.sv
      - hdl/wordRing.sv
      - hdl/memArbiter.sv
      - hdl/wordRam.sv
      - hdl/milBufferBridge.sv
  - target: simulation
    files:
      - tb/milBridgeTb.sv

// File: hdl/memArbiter.sv
`timescale 1ns/1ns

module memArbiter import milStdPkg::*; #(
	parameter int AddrWidth = 4
) (
	input logic clk,
	input logic rst,
	input logic wrReq,
	input logic [AddrWidth-1:0] wrAddr,
	input logic [15:0] wrData,
	output logic wrGrant,
	input logic rdReq,
	input logic [AddrWidth-1:0] rdAddr,
	output logic rdGrant,
	input logic [AddrWidth:0] paddr,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [15:0] pwdata,
	output logic [15:0] prdata,
	output logic pready,
	output logic pslverr,
	input logic [AddrWidth:0] count,
	input logic full,
	input logic empty,
	output logic ramEn,
	output logic ramWe,
	output logic [AddrWidth-1:0] ramAddr,
	output logic [15:0] ramWdata,
	input logic [15:0] ramRdata
);

	typedef enum logic {
		A_IDLE,
		A_DATA
	} ApbState;

	ApbState apbState;
	Requester lastGrant, winner;
	logic window, access, hostReq, hostGrant;
	logic [15:0] statusWord;

	assign window = paddr[AddrWidth];
	assign access = psel && penable;
	assign hostReq = access && !pwrite && window && (apbState == A_IDLE);

	// the requester after the last winner gets first pick.
	always_comb begin
		winner = REQ_NONE;
		case (lastGrant)
			REQ_WRITE: begin
				if (rdReq) winner = REQ_READ;
				else if (hostReq) winner = REQ_HOST;
				else if (wrReq) winner = REQ_WRITE;
			end
			REQ_READ: begin
				if (hostReq) winner = REQ_HOST;
				else if (wrReq) winner = REQ_WRITE;
				else if (rdReq) winner = REQ_READ;
			end
			default: begin
				if (wrReq) winner = REQ_WRITE;
				else if (rdReq) winner = REQ_READ;
				else if (hostReq) winner = REQ_HOST;
			end
		endcase
	end

	assign wrGrant = (winner == REQ_WRITE);
	assign rdGrant = (winner == REQ_READ);
	assign hostGrant = (winner == REQ_HOST);

	assign ramEn = (winner != REQ_NONE);
	assign ramWe = wrGrant;
	assign ramWdata = wrData;
	assign ramAddr = wrGrant ? wrAddr : (rdGrant ? rdAddr : paddr[AddrWidth-1:0]);

	always_ff @(posedge clk) begin
		if (rst) begin
			lastGrant <= REQ_NONE;
			apbState <= A_IDLE;
		end else begin
			if (winner != REQ_NONE)
				lastGrant <= winner;
			apbState <= hostGrant ? A_DATA : A_IDLE; // ram data is ready one cycle on.
		end
	end

	always_comb begin
		statusWord = '0;
		statusWord[AddrWidth:0] = count;
		statusWord[15] = full;
		statusWord[14] = empty;
	end

	// writes are refused, status reads need no wait state.
	assign pready = access && (pwrite || !window || apbState == A_DATA);
	assign pslverr = access && pwrite;
	assign prdata = window ? ramRdata : statusWord;

	assert property (@(posedge clk) disable iff (rst)
		$onehot0({wrGrant, rdGrant, hostGrant}));
	assert property (@(posedge clk) disable iff (rst) hostGrant |=> pready);

endmodule

// File: hdl/memMilEncoder.sv
`timescale 1ns/1ns

module memMilEncoder import milStdPkg::*; (
	input logic clk,
	input logic rst,
	input logic decRequest,
	input logic [15:0] decData,
	output logic decDone,
	output logic txRequest,
	output WordType txType,
	output logic [15:0] txWord,
	input logic txDone
);

	typedef enum logic [2:0] {
		IDLE,
		ESC_DONE,
		WORD_WAIT,
		WORD_LATCH,
		WORD_SEND,
		TX_WAIT,
		WORD_DONE
	} State;

	State state, next;
	WordType pendType;
	logic isEsc;

	assign isEsc = (decData[15:2] == EscMask);

	assign decDone = (state == ESC_DONE) || (state == WORD_DONE);
	assign txRequest = (state == WORD_SEND);

	always_ff @(posedge clk) begin
		if (rst)
			state <= IDLE;
		else
			state <= next;
	end

	always_ff @(posedge clk) begin
		if (state == IDLE && decRequest)
			pendType <= isEsc ? typeFor(decData) : WDATA;
		if (state == WORD_LATCH) begin
			txWord <= decData; // push data stays valid until decDone.
			txType <= pendType;
		end
	end

	always_comb begin
		next = state;
		case (state)
			IDLE: begin
				if (decRequest)
					next = isEsc ? ESC_DONE : WORD_LATCH;
			end
			ESC_DONE: next = WORD_WAIT;
			WORD_WAIT: begin
				// word after an escape is payload, even if it matches the mask.
				if (decRequest)
					next = WORD_LATCH;
			end
			WORD_LATCH: next = WORD_SEND;
			WORD_SEND: next = txDone ? WORD_DONE : TX_WAIT;
			TX_WAIT: begin
				if (txDone)
					next = WORD_DONE;
			end
			WORD_DONE: next = IDLE;
			default: next = IDLE;
		endcase
	end

	assert property (@(posedge clk) disable iff (rst)
		txRequest |=> !txRequest);

endmodule

// File: hdl/milBufferBridge.sv
`timescale 1ns/1ns

module milBufferBridge import milStdPkg::*; #(
	parameter int AddrWidth = 4
) (
	input logic clk,
	input logic rst,
	input logic rxRequest,
	input WordType rxType,
	input logic [15:0] rxWord,
	output logic rxDone,
	output logic txRequest,
	output WordType txType,
	output logic [15:0] txWord,
	input logic txDone,
	input logic [AddrWidth:0] paddr,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [15:0] pwdata,
	output logic [15:0] prdata,
	output logic pready,
	output logic pslverr
);

	logic encWrRequest, encWrDone;
	logic [15:0] encWrData;
	logic decRequest, decDone;
	logic [15:0] decData;
	logic wrReq, wrGrant, rdReq, rdGrant;
	logic [AddrWidth-1:0] wrAddr, rdAddr, ramAddr;
	logic [15:0] wrData, ramWdata, ramRdata;
	logic ramEn, ramWe;
	logic [AddrWidth:0] count;
	logic full, empty;

	milMemEncoder encoder (
		.clk, .rst, .rxRequest, .rxType, .rxWord, .rxDone,
		.encWrRequest, .encWrData, .encWrDone
	);

	wordRing #(.AddrWidth(AddrWidth)) ring (
		.clk, .rst, .encWrRequest, .encWrData, .encWrDone,
		.decRequest, .decData, .decDone,
		.wrReq, .wrAddr, .wrData, .wrGrant,
		.rdReq, .rdAddr, .rdGrant, .ramRdata,
		.count, .full, .empty
	);

	memArbiter #(.AddrWidth(AddrWidth)) arbiter (
		.clk, .rst, .wrReq, .wrAddr, .wrData, .wrGrant,
		.rdReq, .rdAddr, .rdGrant,
		.paddr, .psel, .penable, .pwrite, .pwdata, .prdata, .pready, .pslverr,
		.count, .full, .empty,
		.ramEn, .ramWe, .ramAddr, .ramWdata, .ramRdata
	);

	wordRam #(.AddrWidth(AddrWidth)) ram (
		.clk, .ramEn, .ramWe, .ramAddr, .ramWdata, .ramRdata
	);

	memMilEncoder decoder (
		.clk, .rst, .decRequest, .decData, .decDone,
		.txRequest, .txType, .txWord, .txDone
	);

endmodule

// File: hdl/milMemEncoder.sv
`timescale 1ns/1ns

module milMemEncoder import milStdPkg::*; (
	input logic clk,
	input logic rst,
	input logic rxRequest,
	input WordType rxType,
	input logic [15:0] rxWord,
	output logic rxDone,
	output logic encWrRequest,
	output logic [15:0] encWrData,
	input logic encWrDone
);

	typedef enum logic [2:0] {
		IDLE,
		ESC_LOAD,
		ESC_WAIT,
		WORD_LOAD,
		WORD_WAIT,
		REPORT
	} State;

	State state, next;
	logic needEsc;
	logic [15:0] data;

	// non data words and colliding payloads get an escape word first.
	assign needEsc = (rxType != WDATA) || (rxWord[15:2] == EscMask);

	assign encWrRequest = (state == ESC_LOAD) || (state == WORD_LOAD);
	assign encWrData = data;
	assign rxDone = (state == REPORT);

	always_ff @(posedge clk) begin
		if (rst)
			state <= IDLE;
		else
			state <= next;
	end

	always_ff @(posedge clk) begin
		if (next == ESC_LOAD)
			data <= escFor(rxType);
		else if (next == WORD_LOAD)
			data <= rxWord; // source holds the word until rxDone.
	end

	always_comb begin
		next = state;
		case (state)
			IDLE: begin
				if (rxRequest)
					next = needEsc ? ESC_LOAD : WORD_LOAD;
			end
			ESC_LOAD: next = ESC_WAIT;
			ESC_WAIT: begin
				if (encWrDone)
					next = WORD_LOAD;
			end
			WORD_LOAD: next = WORD_WAIT;
			WORD_WAIT: begin
				if (encWrDone)
					next = REPORT;
			end
			REPORT: next = IDLE;
			default: next = IDLE;
		endcase
	end

	// push requests are single cycle pulses.
	assert property (@(posedge clk) disable iff (rst)
		encWrRequest |=> !encWrRequest);

endmodule

// File: hdl/milStdPkg.sv
package milStdPkg;

	typedef enum logic [1:0] {
		WDATA,
		WCOMMAND,
		WSTATUS,
		WERROR
	} WordType;

	localparam logic [15:0] EscError = 16'hFFA0;
	localparam logic [15:0] EscCommand = 16'hFFA1;
	localparam logic [15:0] EscStatus = 16'hFFA2;
	localparam logic [15:0] EscData = 16'hFFA3;
	localparam logic [13:0] EscMask = 14'h3FE8; // FFA0 without its low two bits.

	typedef enum logic [1:0] {
		REQ_NONE,
		REQ_WRITE,
		REQ_READ,
		REQ_HOST
	} Requester;

	function automatic logic [15:0] escFor(WordType kind);
		case (kind)
			WCOMMAND: return EscCommand;
			WSTATUS: return EscStatus;
			WERROR: return EscError;
			default: return EscData; // colliding data payload.
		endcase
	endfunction

	function automatic WordType typeFor(logic [15:0] esc);
		case (esc)
			EscError: return WERROR;
			EscCommand: return WCOMMAND;
			EscStatus: return WSTATUS;
			default: return WDATA;
		endcase
	endfunction

endpackage

// File: hdl/wordRam.sv
`timescale 1ns/1ns

module wordRam #(
	parameter int AddrWidth = 4
) (
	input logic clk,
	input logic ramEn,
	input logic ramWe,
	input logic [AddrWidth-1:0] ramAddr,
	input logic [15:0] ramWdata,
	output logic [15:0] ramRdata
);

	logic [15:0] mem [2**AddrWidth];

	// read data follows the enabled cycle by one clock.
	always_ff @(posedge clk) begin
		if (ramEn) begin
			if (ramWe)
				mem[ramAddr] <= ramWdata;
			else
				ramRdata <= mem[ramAddr];
		end
	end

endmodule

// File: hdl/wordRing.sv
`timescale 1ns/1ns

module wordRing #(
	parameter int AddrWidth = 4
) (
	input logic clk,
	input logic rst,
	input logic encWrRequest,
	input logic [15:0] encWrData,
	output logic encWrDone,
	output logic decRequest,
	output logic [15:0] decData,
	input logic decDone,
	output logic wrReq,
	output logic [AddrWidth-1:0] wrAddr,
	output logic [15:0] wrData,
	input logic wrGrant,
	output logic rdReq,
	output logic [AddrWidth-1:0] rdAddr,
	input logic rdGrant,
	input logic [15:0] ramRdata,
	output logic [AddrWidth:0] count,
	output logic full,
	output logic empty
);

	typedef enum logic [1:0] {
		R_IDLE,
		R_FETCH,
		R_PUSH,
		R_WAIT
	} RdState;

	RdState rdState;
	logic [AddrWidth-1:0] head, tail;
	logic wrPending;
	logic popDone;

	assign full = (count == (AddrWidth+1)'(1 << AddrWidth));
	assign empty = (count == '0);

	assign wrReq = wrPending && !full; // held back while full.
	assign wrAddr = head;
	assign wrData = encWrData;
	assign encWrDone = wrGrant;

	assign rdReq = (rdState == R_IDLE) && !empty;
	assign rdAddr = tail;
	assign decRequest = (rdState == R_PUSH);
	assign popDone = (rdState == R_WAIT) && decDone;

	always_ff @(posedge clk) begin
		if (rst) begin
			wrPending <= 1'b0;
			head <= '0;
		end else if (wrGrant) begin
			wrPending <= 1'b0;
			head <= head + 1'b1;
		end else if (encWrRequest)
			wrPending <= 1'b1;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			rdState <= R_IDLE;
			tail <= '0;
		end else begin
			case (rdState)
				R_IDLE: if (rdGrant) rdState <= R_FETCH;
				R_FETCH: rdState <= R_PUSH;
				R_PUSH: rdState <= R_WAIT;
				R_WAIT: begin
					if (decDone) begin
						rdState <= R_IDLE;
						tail <= tail + 1'b1; // slot freed only once the word is taken.
					end
				end
				default: rdState <= R_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (rdState == R_FETCH)
			decData <= ramRdata;
	end

	always_ff @(posedge clk) begin
		if (rst)
			count <= '0;
		else if (wrGrant && !popDone)
			count <= count + 1'b1;
		else if (popDone && !wrGrant)
			count <= count - 1'b1;
	end

	assert property (@(posedge clk) disable iff (rst) wrGrant |-> !full);
	assert property (@(posedge clk) disable iff (rst) rdGrant |-> !empty);

endmodule

// File: list.f
hdl/milStdPkg.sv
hdl/milMemEncoder.sv
hdl/memMilEncoder.sv
hdl/wordRing.sv
hdl/memArbiter.sv
hdl/wordRam.sv
hdl/milBufferBridge.sv
tb/milBridgeTb.sv

// File: tb/milBridgeTb.sv
`timescale 1ns/1ns

module milBridgeTb import milStdPkg::*; ();

	localparam int AddrWidth = 4;
	localparam int Depth = 1 << AddrWidth;
	localparam int WaitLimit = 60;

	logic clk, rst;
	logic rxRequest, rxDone, txRequest, txDone;
	WordType rxType, txType;
	logic [15:0] rxWord, txWord;
	logic [AddrWidth:0] paddr;
	logic psel, penable, pwrite, pready, pslverr;
	logic [15:0] pwdata, prdata;

	logic [17:0] expected [$]; // type and payload in send order.
	logic [15:0] modelMem [Depth];
	bit written [Depth];
	logic [AddrWidth-1:0] modelHead;
	bit holdTx;
	int errors, checks, testStart, tests;

	milBufferBridge #(.AddrWidth(AddrWidth)) UUT (
		.clk, .rst, .rxRequest, .rxType, .rxWord, .rxDone,
		.txRequest, .txType, .txWord, .txDone,
		.paddr, .psel, .penable, .pwrite, .pwdata, .prdata, .pready, .pslverr
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// escape word that goes in front of the payload, if any.
	function automatic bit escapeWord(input WordType kind, input logic [15:0] payload,
			output logic [15:0] escWord);
		escWord = 16'h0000;
		case (kind)
			WCOMMAND: escWord = EscCommand;
			WSTATUS: escWord = EscStatus;
			WERROR: escWord = EscError;
			default: if ((payload & 16'hFFFC) == 16'hFFA0) escWord = EscData;
		endcase
		return escWord != 16'h0000;
	endfunction

	function automatic logic [15:0] randomPayload();
		if ($urandom % 4 == 0)
			return 16'hFFA0 | 16'($urandom % 4); // lands on an escape code.
		return 16'($urandom);
	endfunction

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] want);
		checks++;
		if (got !== want) begin
			errors++;
			$display("mismatch %s got %h expected %h", name, got, want);
		end
	endtask

	task automatic recordWord(input WordType kind, input logic [15:0] payload);
		logic [15:0] escWord;
		if (escapeWord(kind, payload, escWord)) begin
			modelMem[modelHead] = escWord;
			written[modelHead] = 1'b1;
			modelHead++;
		end
		modelMem[modelHead] = payload;
		written[modelHead] = 1'b1;
		modelHead++;
		expected.push_back({kind, payload});
	endtask

	task automatic sendWord(input WordType kind, input logic [15:0] payload, output bit accepted);
		int waited;
		@(negedge clk);
		rxType = kind;
		rxWord = payload;
		rxRequest = 1'b1;
		recordWord(kind, payload);
		waited = 0;
		accepted = 1'b0;
		while (!accepted && waited < WaitLimit) begin
			@(negedge clk);
			if (rxDone)
				accepted = 1'b1;
			else
				waited++;
		end
		if (accepted)
			rxRequest = 1'b0; // dropped inside the rxDone cycle.
	endtask

	task automatic finishRx();
		int waited;
		waited = 0;
		while (!rxDone && waited < WaitLimit) begin
			@(negedge clk);
			waited++;
		end
		if (!rxDone) begin
			errors++;
			$display("stalled receive word was never accepted");
		end
		rxRequest = 1'b0;
	endtask

	task automatic apbAccess(input logic wr, input logic [AddrWidth:0] addr,
			input logic [15:0] wdata, output logic [15:0] rdata, output logic err);
		int waited;
		@(negedge clk);
		paddr = addr;
		pwrite = wr;
		pwdata = wdata;
		psel = 1'b1;
		penable = 1'b0;
		@(negedge clk);
		penable = 1'b1;
		waited = 0;
		#1;
		while (!pready && waited < WaitLimit) begin
			@(negedge clk);
			#1;
			waited++;
		end
		if (!pready) begin
			errors++;
			$display("APB transfer to address %h never completed", addr);
		end
		rdata = prdata;
		err = pslverr;
		@(negedge clk);
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
	endtask

	task automatic waitDrained();
		int waited;
		logic [15:0] status;
		logic err;
		waited = 0;
		while (expected.size() != 0 && waited < 20 * WaitLimit) begin
			@(negedge clk);
			waited++;
		end
		if (expected.size() != 0) begin
			errors++;
			$display("%0d words never came out of the transmit side", expected.size());
		end
		waited = 0;
		status = 16'h0000;
		while (!status[14] && waited < 20) begin
			apbAccess(1'b0, '0, 16'h0000, status, err);
			waited++;
		end
		if (!status[14]) begin
			errors++;
			$display("ring did not report empty after draining");
		end
	endtask

	task automatic endTest(input string name);
		tests++;
		$display("test %0d %s: %0d failures", tests, name, errors - testStart);
		testStart = errors;
	endtask

	initial begin : txSink
		bit owed;
		owed = 1'b0;
		txDone = 1'b0;
		forever begin
			@(negedge clk);
			txDone = 1'b0;
			if (txRequest)
				owed = 1'b1;
			if (owed && !holdTx) begin
				txDone = 1'b1;
				owed = 1'b0;
			end
		end
	end

	initial begin : compareTx
		logic [17:0] want;
		forever begin
			@(negedge clk);
			if (txRequest) begin
				if (expected.size() == 0) begin
					errors++;
					$display("txRequest arrived with no word expected");
				end else begin
					want = expected.pop_front();
					check("txType", txType, want[17:16]);
					check("txWord", txWord, want[15:0]);
				end
			end
		end
	end

	initial begin
		logic [15:0] data;
		logic err;
		bit accepted, stalled;
		rst = 1'b1;
		rxRequest = 1'b0;
		rxType = WDATA;
		rxWord = 16'h0000;
		paddr = '0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		pwdata = 16'h0000;
		holdTx = 1'b0;
		modelHead = '0;
		errors = 0;
		checks = 0;
		testStart = 0;
		tests = 0;
		void'($urandom(89));
		repeat (8) @(negedge clk);
		rst = 1'b0;

		@(negedge clk);
		check("txRequest", txRequest, 1'b0);
		check("rxDone", rxDone, 1'b0);
		apbAccess(1'b0, '0, 16'h0000, data, err);
		check("status", data, 16'h4000);
		endTest("reset state");

		for (int i = 0; i < 4; i++) begin
			sendWord(WDATA, 16'hFFA0 + 16'(i), accepted);
			if (!accepted)
				$display("rxDone missing for colliding payload %0d", i);
			if (!accepted)
				errors++;
		end
		for (int i = 0; i < 40; i++) begin
			sendWord(WordType'($urandom % 4), randomPayload(), accepted);
			if (!accepted) begin
				errors++;
				rxRequest = 1'b0;
				$display("rxDone missing for random word %0d", i);
			end
		end
		waitDrained();
		endTest("random traffic");

		holdTx = 1'b1; // sink stops answering.
		stalled = 1'b0;
		for (int i = 0; i < 24 && !stalled; i++) begin
			sendWord(WordType'($urandom % 4), randomPayload(), accepted);
			stalled = !accepted;
		end
		if (!stalled) begin
			errors++;
			$display("ring never filled while transmit was held");
		end
		apbAccess(1'b0, '0, 16'h0000, data, err);
		check("status", data, 16'h8000 | 16'(Depth));
		holdTx = 1'b0;
		finishRx();
		waitDrained();
		endTest("back pressure");

		for (int i = 0; i < Depth; i++) begin
			if (written[i]) begin
				apbAccess(1'b0, (AddrWidth+1)'(Depth + i), 16'h0000, data, err);
				check("prdata", data, modelMem[i]);
				check("pslverr", err, 1'b0);
			end
		end
		endTest("window reads");

		// the ring is drained, so status reads empty with count zero.
		apbAccess(1'b0, '0, 16'h0000, data, err);
		check("status", data, 16'h4000);
		apbAccess(1'b1, '0, 16'h1234, data, err);
		check("pslverr", err, 1'b1);
		apbAccess(1'b1, (AddrWidth+1)'(Depth), 16'h5678, data, err);
		check("pslverr", err, 1'b1);
		apbAccess(1'b0, '0, 16'h0000, data, err);
		check("status", data, 16'h4000);
		apbAccess(1'b0, (AddrWidth+1)'(Depth), 16'h0000, data, err);
		check("prdata", data, modelMem[0]);
		endTest("refused writes");

		$display("%0d tests, %0d checks, %0d failures", tests, checks, errors);
		if (errors == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule
